// File: common/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// datapath width of the integer core
`define XLEN 64

// register index width, enough for x0..x31
`define REG_ADDR_W 5

// integer registers including x0
`define REG_COUNT 32

`endif

// File: common/wb_pkg.sv
`include "wb_config.svh"

package wb_pkg;

    // width change applied to the result before the register write
    typedef enum logic [2:0] {
        FULL   = 3'd0,
        SEXT_W = 3'd1,
        ZEXT_W = 3'd2,
        SEXT_H = 3'd3,
        ZEXT_H = 3'd4,
        SEXT_B = 3'd5,
        ZEXT_B = 3'd6
    } ext_mode_e; // 3'd7 unused, no write

    // which unit produced the retiring value
    typedef enum logic {
        SRC_EX  = 1'b0,
        SRC_MEM = 1'b1  // load data
    } res_src_e;

    typedef struct packed {
        logic [7:0] b1;
        logic [7:0] b0;
    } half_s;

    typedef struct packed {
        half_s h1;
        half_s h0;
    } word_s;

    typedef struct packed {
        word_s w1;
        word_s w0;  // low word, what the W/H/B modes look at
    } dword_s;

    // one result word, seen whole or broken down for the extend logic
    typedef union packed {
        logic [`XLEN-1:0] dword;
        dword_s           words;
    } wb_data_u;

endpackage

// File: common/rf_write_if.sv
`timescale 1ns/1ps
`include "wb_config.svh"

// single write port into the integer register file
interface rf_write_if;

    logic                   wen;     // one-cycle strobe, no back-pressure
    logic [`REG_ADDR_W-1:0] waddr;
    logic [`XLEN-1:0]       wdata;   // already extended
    logic                   halted;  // sticky ebreak flag rides along to the top

    modport source (
        output wen,
        output waddr,
        output wdata,
        output halted
    );

    // register file only needs the write itself
    modport sink (
        input wen,
        input waddr,
        input wdata
    );

endinterface

// File: design/wb_select.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_select (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   ret_valid,
    input  logic                   ret_wen,
    input  logic [`REG_ADDR_W-1:0] ret_rd,
    input  wb_pkg::res_src_e       ret_src,
    input  wb_pkg::ext_mode_e      ret_ext,
    input  logic                   ret_store,
    input  logic [31:0]            ret_imm,
    input  logic [`XLEN/8-1:0]     ret_mask,
    input  logic                   ret_ebreak,
    input  logic [`XLEN-1:0]       ret_pc,

    input  logic [`XLEN-1:0]       ex_res,
    input  logic [`XLEN-1:0]       mem_res,

    rf_write_if.source             rf,

    output logic                   st_req,
    output logic [31:0]            st_imm,
    output logic [`XLEN-1:0]       st_data,
    output logic [`XLEN/8-1:0]     st_mask,

    output logic [`XLEN-1:0]       commit_pc
);

    wb_pkg::wb_data_u res;
    logic [`XLEN-1:0] ext_val;
    logic             ext_ok;
    logic             halted_q;
    logic             taken;
    logic             take_ebreak;
    logic             take_store;

    assign taken       = ret_valid && !halted_q;  // nothing retires once halted
    assign take_ebreak = taken && ret_ebreak;
    assign take_store  = taken && !ret_ebreak && ret_store;

    // result source, then width handling through the union views
    always_comb begin
        res.dword = (ret_src == wb_pkg::SRC_MEM) ? mem_res : ex_res;
        ext_ok    = 1'b1;
        case (ret_ext)
            wb_pkg::FULL:   ext_val = res.dword;
            wb_pkg::SEXT_W: ext_val = {{32{res.words.w0[31]}}, res.words.w0};
            wb_pkg::ZEXT_W: ext_val = {32'd0, res.words.w0};
            wb_pkg::SEXT_H: ext_val = {{48{res.words.w0.h0[15]}}, res.words.w0.h0};
            wb_pkg::ZEXT_H: ext_val = {48'd0, res.words.w0.h0};
            wb_pkg::SEXT_B: ext_val = {{56{res.words.w0.h0.b0[7]}}, res.words.w0.h0.b0};
            wb_pkg::ZEXT_B: ext_val = {56'd0, res.words.w0.h0.b0};
            default: begin
                ext_val = res.dword;
                ext_ok  = 1'b0;  // unknown mode drops the write
            end
        endcase
    end

    // ebreak beats store, store beats register write
    assign rf.wen    = taken && !ret_ebreak && !ret_store && ret_wen
                       && (ret_rd != '0) && ext_ok;
    assign rf.waddr  = ret_rd;
    assign rf.wdata  = ext_val;
    assign rf.halted = halted_q;

    assign st_req  = take_store;
    assign st_imm  = ret_imm;
    assign st_data = res.dword;  // memory gets the raw value, lanes picked by mask
    assign st_mask = ret_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_q <= 1'b0;
        end else if (take_ebreak) begin
            halted_q <= 1'b1;  // held until reset
        end
    end

    // trace pc of the last taken retire
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_pc <= '0;
        end else if (taken) begin
            commit_pc <= ret_pc;
        end
    end

endmodule

// File: regfile/regfile.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module regfile (
    input  logic                   clk,
    input  logic                   rst_n,

    rf_write_if.sink               wr,

    // a feeds the store base, b the debug read
    input  logic [`REG_ADDR_W-1:0] raddr_a,
    input  logic [`REG_ADDR_W-1:0] raddr_b,
    output logic [`XLEN-1:0]       rdata_a,
    output logic [`XLEN-1:0]       rdata_b
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 filtering happens upstream, the array just takes the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wen) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // combinational reads, x0 hardwired to zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// File: design/store_unit.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module store_unit (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               st_req,
    input  logic [`XLEN-1:0]   st_base,   // rs1 as read this cycle
    input  logic [31:0]        st_imm,
    input  logic [`XLEN-1:0]   st_data,
    input  logic [`XLEN/8-1:0] st_mask,

    output logic               st_valid,
    output logic [`XLEN-1:0]   st_addr,
    output logic [`XLEN-1:0]   st_data_q,
    output logic [`XLEN/8-1:0] st_mask_q
);

    logic [`XLEN-1:0] eff_addr;

    // base plus sign-extended offset
    assign eff_addr = st_base + {{(`XLEN-32){st_imm[31]}}, st_imm};

    // one-cycle strobe to data memory
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid <= 1'b0;
        end else begin
            st_valid <= st_req;
        end
    end

    // payload only loads on a request, qualified by st_valid downstream
    always_ff @(posedge clk) begin
        if (st_req) begin
            st_addr   <= eff_addr;
            st_data_q <= st_data;
            st_mask_q <= st_mask;
        end
    end

endmodule

// File: design/wb_top.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // retire strobe from the memory stage
    input  logic                   ret_valid,
    input  logic                   ret_wen,
    input  logic [`REG_ADDR_W-1:0] ret_rd,
    input  wb_pkg::res_src_e       ret_src,
    input  wb_pkg::ext_mode_e      ret_ext,
    input  logic                   ret_store,
    input  logic [`REG_ADDR_W-1:0] ret_rs1,
    input  logic [31:0]            ret_imm,
    input  logic [`XLEN/8-1:0]     ret_mask,
    input  logic                   ret_ebreak,
    input  logic [`XLEN-1:0]       ret_pc,

    input  logic [`XLEN-1:0]       ex_res,
    input  logic [`XLEN-1:0]       mem_res,

    input  logic [`REG_ADDR_W-1:0] dbg_raddr,
    output logic [`XLEN-1:0]       dbg_rdata,

    output logic                   halted,
    output logic [`XLEN-1:0]       commit_pc,

    // data memory write side
    output logic                   st_valid,
    output logic [`XLEN-1:0]       st_addr,
    output logic [`XLEN-1:0]       st_data,
    output logic [`XLEN/8-1:0]     st_mask
);

    rf_write_if rf_wr ();

    logic                   st_req;
    logic [31:0]            st_imm;
    logic [`XLEN-1:0]       st_wdata;
    logic [`XLEN/8-1:0]     st_wmask;
    logic [`XLEN-1:0]       st_base;

    wb_select u_wb_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .ret_valid  (ret_valid),
        .ret_wen    (ret_wen),
        .ret_rd     (ret_rd),
        .ret_src    (ret_src),
        .ret_ext    (ret_ext),
        .ret_store  (ret_store),
        .ret_imm    (ret_imm),
        .ret_mask   (ret_mask),
        .ret_ebreak (ret_ebreak),
        .ret_pc     (ret_pc),
        .ex_res     (ex_res),
        .mem_res    (mem_res),
        .rf         (rf_wr.source),
        .st_req     (st_req),
        .st_imm     (st_imm),
        .st_data    (st_wdata),
        .st_mask    (st_wmask),
        .commit_pc  (commit_pc)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (rf_wr.sink),
        .raddr_a (ret_rs1),    // store base
        .raddr_b (dbg_raddr),
        .rdata_a (st_base),
        .rdata_b (dbg_rdata)
    );

    store_unit u_store_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .st_req    (st_req),
        .st_base   (st_base),
        .st_imm    (st_imm),
        .st_data   (st_wdata),
        .st_mask   (st_wmask),
        .st_valid  (st_valid),
        .st_addr   (st_addr),
        .st_data_q (st_data),
        .st_mask_q (st_mask)
    );

    assign halted = rf_wr.halted;

endmodule

// File: sim/tb_wb.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module tb_wb;

    localparam int PERIOD      = 100;
    localparam int RST_CYCLES  = 2;
    localparam int N_EXT       = 32;  // 8 modes x 2 sources x 2
    localparam int N_X0        = 8;
    localparam int N_ST        = 6;
    localparam int N_B2B       = 12;
    localparam int N_POST      = 6;   // retires offered after ebreak
    localparam int PLAN_CYCLES = RST_CYCLES + `REG_COUNT + N_EXT + N_X0 + N_ST + N_B2B
                                 + 1 + N_POST + 8;
    localparam int TIMEOUT     = (PLAN_CYCLES + 20) * PERIOD;

    logic                   clk;
    logic                   rst_n;
    logic                   ret_valid;
    logic                   ret_wen;
    logic [`REG_ADDR_W-1:0] ret_rd;
    wb_pkg::res_src_e       ret_src;
    wb_pkg::ext_mode_e      ret_ext;
    logic                   ret_store;
    logic [`REG_ADDR_W-1:0] ret_rs1;
    logic [31:0]            ret_imm;
    logic [`XLEN/8-1:0]     ret_mask;
    logic                   ret_ebreak;
    logic [`XLEN-1:0]       ret_pc;
    logic [`XLEN-1:0]       ex_res;
    logic [`XLEN-1:0]       mem_res;
    logic [`REG_ADDR_W-1:0] dbg_raddr;
    logic [`XLEN-1:0]       dbg_rdata;
    logic                   halted;
    logic [`XLEN-1:0]       commit_pc;
    logic                   st_valid;
    logic [`XLEN-1:0]       st_addr;
    logic [`XLEN-1:0]       st_data;
    logic [`XLEN/8-1:0]     st_mask;

    // reference model state
    logic [`XLEN-1:0]       exp_regs [`REG_COUNT];
    logic                   exp_halted;
    logic [`XLEN-1:0]       exp_commit_pc;
    logic                   exp_st_valid;
    logic [`XLEN-1:0]       exp_st_addr;
    logic [`XLEN-1:0]       exp_st_data;
    logic [`XLEN/8-1:0]     exp_st_mask;
    logic [`XLEN-1:0]       src_val;
    logic [`XLEN-1:0]       base_val;

    integer                 seed;
    int                     errors = 0;
    logic [`REG_ADDR_W-1:0] last_rd;  // register to look at one cycle after its retire
    logic [`XLEN-1:0]       next_pc;

    wb_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ret_valid  (ret_valid),
        .ret_wen    (ret_wen),
        .ret_rd     (ret_rd),
        .ret_src    (ret_src),
        .ret_ext    (ret_ext),
        .ret_store  (ret_store),
        .ret_rs1    (ret_rs1),
        .ret_imm    (ret_imm),
        .ret_mask   (ret_mask),
        .ret_ebreak (ret_ebreak),
        .ret_pc     (ret_pc),
        .ex_res     (ex_res),
        .mem_res    (mem_res),
        .dbg_raddr  (dbg_raddr),
        .dbg_rdata  (dbg_rdata),
        .halted     (halted),
        .commit_pc  (commit_pc),
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_data    (st_data),
        .st_mask    (st_mask)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // width rules of the extension modes as masks
    function automatic logic [63:0] extend_value(input logic [2:0] mode, input logic [63:0] v);
        logic [63:0] lo32;
        logic [63:0] lo16;
        logic [63:0] lo8;
        lo32 = v & 64'h0000_0000_ffff_ffff;
        lo16 = v & 64'h0000_0000_0000_ffff;
        lo8  = v & 64'h0000_0000_0000_00ff;
        case (mode)
            3'd0: extend_value = v;
            3'd1: extend_value = v[31] ? (lo32 | 64'hffff_ffff_0000_0000) : lo32;
            3'd2: extend_value = lo32;
            3'd3: extend_value = v[15] ? (lo16 | 64'hffff_ffff_ffff_0000) : lo16;
            3'd4: extend_value = lo16;
            3'd5: extend_value = v[7] ? (lo8 | 64'hffff_ffff_ffff_ff00) : lo8;
            3'd6: extend_value = lo8;
            default: extend_value = v;  // no write for this code anyway
        endcase
    endfunction

    // reference model sees the inputs driven for the cycle ending at this edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                exp_regs[i] <= '0;
            end
            exp_halted    <= 1'b0;
            exp_commit_pc <= '0;
            exp_st_valid  <= 1'b0;
        end else begin
            exp_st_valid <= 1'b0;
            if (ret_valid && !exp_halted) begin
                exp_commit_pc <= ret_pc;
                src_val  = (ret_src == wb_pkg::SRC_MEM) ? mem_res : ex_res;
                base_val = (ret_rs1 == '0) ? '0 : exp_regs[ret_rs1];
                if (ret_ebreak) begin
                    exp_halted <= 1'b1;
                end else if (ret_store) begin
                    exp_st_valid <= 1'b1;
                    exp_st_addr  <= base_val + 64'($signed(ret_imm));
                    exp_st_data  <= src_val;
                    exp_st_mask  <= ret_mask;
                end else if (ret_wen && ret_rd != '0 && ret_ext <= 3'd6) begin
                    exp_regs[ret_rd] <= extend_value(ret_ext, src_val);
                end
            end
        end
    end

    // checks at the falling edge where outputs have settled
    chk_halted: assert property (@(negedge clk) disable iff (!rst_n) halted == exp_halted)
        else begin
            errors++;
            $display("Fail halted expected %h got %h", exp_halted, halted);
        end
    chk_pc: assert property (@(negedge clk) disable iff (!rst_n) commit_pc == exp_commit_pc)
        else begin
            errors++;
            $display("Fail commit_pc expected %h got %h", exp_commit_pc, commit_pc);
        end
    chk_reg: assert property (@(negedge clk) disable iff (!rst_n)
                              dbg_rdata == exp_regs[dbg_raddr])
        else begin
            errors++;
            $display("Fail dbg_rdata x%0d expected %h got %h",
                     dbg_raddr, exp_regs[dbg_raddr], dbg_rdata);
        end
    chk_x0: assert property (@(negedge clk) disable iff (!rst_n)
                             dbg_raddr == '0 |-> dbg_rdata == '0)
        else begin
            errors++;
            $display("Fail dbg_rdata x0 expected %h got %h", 64'd0, dbg_rdata);
        end
    chk_st_valid: assert property (@(negedge clk) disable iff (!rst_n) st_valid == exp_st_valid)
        else begin
            errors++;
            $display("Fail st_valid expected %h got %h", exp_st_valid, st_valid);
        end
    chk_st_addr: assert property (@(negedge clk) disable iff (!rst_n)
                                  exp_st_valid |-> st_addr == exp_st_addr)
        else begin
            errors++;
            $display("Fail st_addr expected %h got %h", exp_st_addr, st_addr);
        end
    chk_st_data: assert property (@(negedge clk) disable iff (!rst_n)
                                  exp_st_valid |-> st_data == exp_st_data)
        else begin
            errors++;
            $display("Fail st_data expected %h got %h", exp_st_data, st_data);
        end
    chk_st_mask: assert property (@(negedge clk) disable iff (!rst_n)
                                  exp_st_valid |-> st_mask == exp_st_mask)
        else begin
            errors++;
            $display("Fail st_mask expected %h got %h", exp_st_mask, st_mask);
        end

    task automatic retire(input logic [4:0] rd, input logic [4:0] rs1, input logic src,
                          input logic [2:0] mode, input logic store, input logic ebreak,
                          input logic wen);
        logic [31:0] r;
        r = $random(seed);
        @(posedge clk);
        ret_valid  <= 1'b1;
        ret_wen    <= wen;
        ret_rd     <= rd;
        ret_src    <= wb_pkg::res_src_e'(src);
        ret_ext    <= wb_pkg::ext_mode_e'(mode);
        ret_store  <= store;
        ret_rs1    <= rs1;
        ret_imm    <= $random(seed);
        ret_mask   <= r[7:0];
        ret_ebreak <= ebreak;
        ret_pc     <= next_pc;
        ex_res     <= {$random(seed), $random(seed)};
        mem_res    <= {$random(seed), $random(seed)};
        dbg_raddr  <= last_rd;  // previous retire's target
        last_rd = rd;
        next_pc = next_pc + 64'd4;
    endtask

    task automatic idle_cycle(input logic [4:0] raddr);
        @(posedge clk);
        ret_valid <= 1'b0;
        dbg_raddr <= raddr;
    endtask

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        pick_reg = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    endfunction

    initial begin
        logic [4:0] rd;
        seed       = 32'hd0beac34;
        last_rd    = '0;
        next_pc    = 64'h8000_0000;
        rst_n      = 1'b0;
        ret_valid  = 1'b0;
        ret_wen    = 1'b0;
        ret_rd     = '0;
        ret_src    = wb_pkg::SRC_EX;
        ret_ext    = wb_pkg::FULL;
        ret_store  = 1'b0;
        ret_rs1    = '0;
        ret_imm    = '0;
        ret_mask   = '0;
        ret_ebreak = 1'b0;
        ret_pc     = '0;
        ex_res     = '0;
        mem_res    = '0;
        dbg_raddr  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int a = 0; a < `REG_COUNT; a++) begin
            idle_cycle(5'(a));  // everything reads zero after reset
        end

        // every mode from both sources including code 7
        for (int i = 0; i < N_EXT; i++) begin
            retire(pick_reg(), 5'd0, i[0], i[3:1], 1'b0, 1'b0, 1'b1);
        end
        for (int i = 0; i < N_X0; i++) begin
            retire(5'd0, 5'd0, i[0], i[2:0], 1'b0, 1'b0, 1'b1);
        end
        idle_cycle(last_rd);

        // stores carry a live rd and a narrow mode, neither may touch the data
        for (int i = 0; i < N_ST; i++) begin
            retire(pick_reg(), pick_reg(), i[0], 3'(i + 1), 1'b1, 1'b0, 1'b1);
        end
        idle_cycle(last_rd);

        // write then store off the freshly written base
        for (int i = 0; i < N_B2B / 2; i++) begin
            rd = pick_reg();
            retire(rd, 5'd0, i[0], 3'd0, 1'b0, 1'b0, 1'b1);
            retire(pick_reg(), rd, ~i[0], 3'd0, 1'b1, 1'b0, 1'b1);
        end
        idle_cycle(last_rd);

        // ebreak also flagged as store and write, only the halt may happen
        retire(pick_reg(), 5'd0, 1'b0, 3'd0, 1'b1, 1'b1, 1'b1);
        for (int i = 0; i < N_POST; i++) begin
            retire(pick_reg(), pick_reg(), i[0], 3'd0, i[0], 1'b0, 1'b1);
        end
        repeat (3) idle_cycle(last_rd);
        @(negedge clk);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the test sequence finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/wb_pkg.sv
common/rf_write_if.sv
design/wb_select.sv
regfile/regfile.sv
design/store_unit.sv
design/wb_top.sv
sim/tb_wb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the writeback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f verilog.f --top-module tb_wb -Mdir "$OBJ"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$OBJ/Vtb_wb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
